/* sources.f */
hw/bus_pkg.sv
hw/isa_pkg.sv
hw/bus_cycle_ctrl.sv
hw/instr_decoder.sv
hw/alu_unit.sv
hw/addr_regs.sv
hw/cpu_top.sv
dv/cpu_sva.sv
dv/cpu_monitor.sv
dv/tb_top.sv

/* dv/tb_top.sv */
`timescale 1ns/10ps

module tb_top
   import bus_pkg::*, isa_pkg::*;
();

   localparam int          NUM_INSTR   = 400;
   // every machine cycle is at most T1, T2, three TW and T3
   localparam int          CYCLE_LIMIT = NUM_INSTR * 3 * 6 + 100;
   localparam time         DRIVE_DLY   = 2;
   localparam logic [31:0] LFSR_SEED   = 32'h2f91_7f7d;
   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

   // opcodes a fetch can return, OUT and MVI show up more often
   localparam logic [32*8-1:0] OPCODES = {
      OPC_NOP, OPC_MVI_A, OPC_MVI_A, OPC_OUT, OPC_OUT, OPC_OUT, OPC_OUT, OPC_JMP,
      8'hc6, 8'hce, 8'hd6, 8'hde, 8'he6, 8'hee, 8'hf6, 8'hfe,
      8'h07, 8'h0f, 8'h17, 8'h1f, 8'h2f, 8'h37, 8'h3f, OPC_OUT,
      8'hc2, 8'hca, 8'hd2, 8'hda, 8'he2, 8'hea, 8'hf2, 8'hfa
   };

   logic        clk;
   logic        reset;
   addr_t       addr;
   byte_t       din;
   byte_t       dout;
   logic        ready;
   bus_ctrl_t   bus;
   logic [31:0] lfsr;
   logic [1:0]  coin;
   int          op_idx;
   int          low_run;
   int          cycles;
   int          errors;
   int          fetches;
   logic        timed_out;

   cpu_top i_dut (
      .clk   (clk),
      .reset (reset),
      .addr  (addr),
      .din   (din),
      .dout  (dout),
      .ready (ready),
      .bus   (bus)
   );

   cpu_monitor i_mon (
      .clk     (clk),
      .reset   (reset),
      .addr    (addr),
      .din     (din),
      .dout    (dout),
      .ready   (ready),
      .bus     (bus),
      .errors  (errors),
      .fetches (fetches)
   );

   always #20 clk = ~clk;

   // galois shift, the bit that falls out is the random bit
   function automatic logic next_random_bit();
      logic bit_out;
      bit_out = lfsr[0];
      lfsr    = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      return bit_out;
   endfunction

   function automatic logic [7:0] random_bits(input int n);
      logic [7:0] val;
      int         i;
      val = '0;
      for (i = 0; i < n; i++)
         val = {val[6:0], next_random_bit()};
      return val;
   endfunction

   // memory answers in T1 and holds the byte through T2 and TW
   always @(posedge clk)
   begin
      #DRIVE_DLY;
      if (bus.sync)
      begin
         if (dout[STAT_M1])
         begin
            op_idx = int'(random_bits(5));
            din    = OPCODES[op_idx*8 +: 8];
         end
         else
            din = random_bits(8);
      end
      // ready drops about one clock in four, never longer than 3 clocks
      coin = 2'(random_bits(2));
      if (coin == 2'b00 && low_run < 3)
      begin
         ready   = 1'b0;
         low_run = low_run + 1;
      end
      else
      begin
         ready   = 1'b1;
         low_run = 0;
      end
   end

   initial
   begin
      clk       = 1'b0;
      reset     = 1'b1;
      ready     = 1'b1;
      din       = '0;
      lfsr      = LFSR_SEED;
      low_run   = 0;
      cycles    = 0;
      timed_out = 1'b0;
      repeat (3) @(posedge clk);
      #DRIVE_DLY reset = 1'b0;

      // the fetch after the last instruction closes it
      while (fetches < NUM_INSTR + 1 && cycles < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycles = cycles + 1;
      end

      timed_out = (fetches < NUM_INSTR + 1);
      if (timed_out)
         $display("timeout: %0d of %0d instructions done after %0d cycles",
                  fetches > 0 ? fetches - 1 : 0, NUM_INSTR, cycles);
      $display("errors: %0d  assertion failures: %0d  timeouts: %0d  cycles: %0d",
               errors, i_dut.i_sva.fail_count, timed_out, cycles);
      if (errors == 0 && i_dut.i_sva.fail_count == 0 && !timed_out)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* dv/cpu_monitor.sv */
`timescale 1ns/10ps

module cpu_monitor
   import bus_pkg::*, isa_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  addr_t     addr,
   input  byte_t     din,
   input  byte_t     dout,
   input  logic      ready,
   input  bus_ctrl_t bus,
   output int        errors,
   output int        fetches
);

   addr_t     pc;
   byte_t     acc;
   psw_t      flags;
   byte_t     op;
   byte_t     lo;
   byte_t     port;
   logic      hi_next;
   cyc_kind_e expect_kind;

   initial
   begin
      errors  = 0;
      fetches = 0;
   end

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected)
      begin
         errors = errors + 1;
         $display("CHECK FAILED at %0t ns: %s expected %h actual %h",
                  $time, name, expected, actual);
      end
   endtask

   function automatic byte_t status_for(input cyc_kind_e kind);
      byte_t st;
      st = '0;
      st[STAT_MEMR] = (kind != CYC_IO_WRITE);
      st[STAT_M1]   = (kind == CYC_FETCH);
      st[STAT_OUT]  = (kind == CYC_IO_WRITE);
      st[STAT_WO_N] = (kind != CYC_IO_WRITE);
      return st;
   endfunction

   function automatic logic cond_true(input logic [2:0] sel);
      case (sel)
         3'd0:    return !flags.z;
         3'd1:    return flags.z;
         3'd2:    return !flags.c;
         3'd3:    return flags.c;
         3'd4:    return !flags.p;
         3'd5:    return flags.p;
         3'd6:    return !flags.s;
         default: return flags.s;
      endcase
   endfunction

   // 9-bit arithmetic, bit 8 is the carry or the borrow
   task automatic run_alu_immediate(input logic [2:0] sel, input byte_t b);
      logic [8:0] wide;
      byte_t      res;
      case (sel)
         3'd0:       wide = {1'b0, acc} + {1'b0, b};
         3'd1:       wide = {1'b0, acc} + {1'b0, b} + {8'd0, flags.c};
         3'd2, 3'd7: wide = {1'b0, acc} - {1'b0, b};
         3'd3:       wide = {1'b0, acc} - {1'b0, b} - {8'd0, flags.c};
         3'd4:       wide = {1'b0, acc & b};
         3'd5:       wide = {1'b0, acc ^ b};
         default:    wide = {1'b0, acc | b};
      endcase
      res     = wide[7:0];
      flags.c = wide[8];
      flags.s = res[7];
      flags.z = (res == 8'h00);
      flags.p = ~^res;
      if (sel != 3'd7)
         acc = res;
   endtask

   task automatic run_acc_group(input logic [2:0] sel);
      byte_t a_old;
      logic  c_old;
      a_old = acc;
      c_old = flags.c;
      case (sel)
         3'd0:    acc = {a_old[6:0], a_old[7]};
         3'd1:    acc = {a_old[0], a_old[7:1]};
         3'd2:    acc = {a_old[6:0], c_old};
         3'd3:    acc = {c_old, a_old[7:1]};
         3'd5:    acc = ~a_old;
         3'd6:    flags.c = 1'b1;
         3'd7:    flags.c = !c_old;
         default: acc = a_old;
      endcase
      // left rotates move bit 7 into carry, right rotates bit 0
      if (sel == 3'd0 || sel == 3'd2)
         flags.c = a_old[7];
      if (sel == 3'd1 || sel == 3'd3)
         flags.c = a_old[0];
   endtask

   function automatic logic needs_operand(input byte_t opc);
      return opc == OPC_MVI_A || opc == OPC_JMP || opc == OPC_OUT
             || (opc[7:6] == 2'b11 && (opc[2:0] == 3'b110 || opc[2:0] == 3'b010));
   endfunction

   task automatic take_operand(input byte_t b);
      expect_kind = CYC_FETCH;
      if (op == OPC_MVI_A)
         acc = b;
      else if (op[7:6] == 2'b11 && op[2:0] == 3'b110)
         run_alu_immediate(op[5:3], b);
      else if (op == OPC_OUT)
      begin
         port        = b;
         expect_kind = CYC_IO_WRITE;
      end
      else if (!hi_next)
      begin
         lo          = b;
         hi_next     = 1'b1;
         expect_kind = CYC_READ;
      end
      else if (op == OPC_JMP || cond_true(op[5:3]))
         pc = {b, lo};
   endtask

   // sampled mid-cycle, where pins and din are settled
   always @(negedge clk)
   begin
      if (reset)
      begin
         pc          = '0;
         acc         = '0;
         flags       = '0;
         op          = OPC_NOP;
         hi_next     = 1'b0;
         expect_kind = CYC_FETCH;
      end
      else if (bus.sync)
      begin
         check_value("addr", expect_kind == CYC_IO_WRITE ? {port, port} : pc, addr);
         check_value("status", status_for(expect_kind), dout);
         if (expect_kind == CYC_FETCH)
            fetches = fetches + 1;
      end
      else if ((bus.dbin || !bus.wr_n) && ready)
      begin
         if (expect_kind == CYC_IO_WRITE)
         begin
            check_value("wr_n", 16'd0, bus.wr_n);
            check_value("dbin", 16'd0, bus.dbin);
            check_value("addr", {port, port}, addr);
            check_value("dout", acc, dout);
            expect_kind = CYC_FETCH;
         end
         else
         begin
            check_value("dbin", 16'd1, bus.dbin);
            check_value("wr_n", 16'd1, bus.wr_n);
            pc = pc + 16'd1;
            if (expect_kind == CYC_FETCH)
            begin
               op      = din;
               hi_next = 1'b0;
               if (needs_operand(din))
                  expect_kind = CYC_READ;
               else if (din[7:6] == 2'b00 && din[2:0] == 3'b111)
                  run_acc_group(din[5:3]);
            end
            else
               take_operand(din);
         end
      end
   end

endmodule

/* dv/cpu_sva.sv */
`timescale 1ns/10ps

module cpu_sva
   import bus_pkg::*;
(
   input logic      clk,
   input logic      reset,
   input logic      ready,
   input bus_ctrl_t bus
);

   int fail_count = 0;

   // sync marks T1 only
   sync_one_clock: assert property (
      @(posedge clk) disable iff (reset) bus.sync |=> !bus.sync)
      else
      begin
         $error("sync high for more than one clock");
         fail_count = fail_count + 1;
      end

   read_write_exclusive: assert property (
      @(posedge clk) disable iff (reset) !(bus.dbin && !bus.wr_n))
      else
      begin
         $error("dbin and wr_n active together");
         fail_count = fail_count + 1;
      end

   wait_follows_ready: assert property (
      @(posedge clk) disable iff (reset) bus.waiting |-> !$past(ready))
      else
      begin
         $error("wait high although ready was high");
         fail_count = fail_count + 1;
      end

   // levels held through reset, seen at the first edge after release
   idle_after_reset: assert property (
      @(posedge clk) $fell(reset) |-> !bus.sync && !bus.dbin && bus.wr_n && !bus.waiting)
      else
      begin
         $error("bus pins not idle at reset release");
         fail_count = fail_count + 1;
      end

endmodule

bind cpu_top cpu_sva i_sva (
   .clk   (clk),
   .reset (reset),
   .ready (ready),
   .bus   (bus)
);

/* hw/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top
   import bus_pkg::*, isa_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   output addr_t     addr,
   input  byte_t     din,
   output byte_t     dout,
   input  logic      ready,
   output bus_ctrl_t bus
);

   mcycle_t    cyc;
   exec_ctrl_t exec;
   addr_ctrl_t actl;
   psw_t       flags;
   byte_t      acc;
   logic       data_strobe;
   logic       cycle_end;

   bus_cycle_ctrl i_bus (
      .clk         (clk),
      .reset       (reset),
      .ready       (ready),
      .cyc         (cyc),
      .acc         (acc),
      .tstate      (),
      .data_strobe (data_strobe),
      .cycle_end   (cycle_end),
      .bus         (bus),
      .dout        (dout)
   );

   instr_decoder i_dec (
      .clk         (clk),
      .reset       (reset),
      .din         (din),
      .data_strobe (data_strobe),
      .cycle_end   (cycle_end),
      .flags       (flags),
      .cyc         (cyc),
      .exec        (exec),
      .actl        (actl)
   );

   alu_unit i_alu (
      .clk         (clk),
      .reset       (reset),
      .din         (din),
      .data_strobe (data_strobe),
      .exec        (exec),
      .acc         (acc),
      .flags       (flags)
   );

   addr_regs i_addr (
      .clk         (clk),
      .reset       (reset),
      .din         (din),
      .data_strobe (data_strobe),
      .actl        (actl),
      .addr        (addr)
   );

endmodule

/* hw/addr_regs.sv */
`timescale 1ns/10ps

module addr_regs
   import bus_pkg::*, isa_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  byte_t      din,
   input  logic       data_strobe,
   input  addr_ctrl_t actl,
   output addr_t      addr
);

   addr_t pc;
   addr_t wz;
   addr_t pc_seq;
   addr_t addr_nxt;

   assign pc_seq = pc + addr_t'(1);

   // I/O port number shows on both halves of the address bus
   always_comb
   begin
      if (actl.port_sel)
         addr_nxt = {wz[7:0], wz[7:0]};
      else if (actl.pc_from_wz)
         addr_nxt = wz;
      else
         addr_nxt = pc;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pc   <= '0;
         wz   <= '0;
         addr <= '0;
      end
      else
      begin
         if (actl.pc_from_wz)
            pc <= wz;
         else if (data_strobe && actl.pc_inc)
            pc <= pc_seq;
         if (data_strobe && actl.wz_lo_load)
            wz[7:0] <= din;
         if (data_strobe && actl.wz_hi_load)
            wz[15:8] <= din;
         // held from T3 through the whole next machine cycle
         if (actl.addr_load)
            addr <= addr_nxt;
      end
   end

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit
   import bus_pkg::*, isa_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  byte_t      din,
   input  logic       data_strobe,
   input  exec_ctrl_t exec,
   output byte_t      acc,
   output psw_t       flags
);

   byte_t      opnd;
   byte_t      x;
   byte_t      res;
   logic [8:0] sum;
   logic       sub_op;
   logic       cin;
   logic       c_nxt;
   logic       upd_szp;
   logic       upd_c;
   logic       acc_we;

   // picks up every byte read, the immediate is the last one before T3
   always_ff @(posedge clk)
   begin
      if (data_strobe)
         opnd <= din;
   end

   // subtraction adds the inverted operand, so carry out means no borrow
   assign sub_op = exec.alu_op inside {ALU_SUB, ALU_SBB, ALU_CMP};
   assign x      = sub_op ? ~opnd : opnd;

   always_comb
   begin
      case (exec.alu_op)
         ALU_ADC:          cin = flags.c;
         ALU_SUB, ALU_CMP: cin = 1'b1;
         ALU_SBB:          cin = !flags.c;
         default:          cin = 1'b0;
      endcase
   end

   assign sum = {1'b0, acc} + {1'b0, x} + {8'd0, cin};

   always_comb
   begin
      case (exec.alu_op)
         ALU_AND:          res = acc & opnd;
         ALU_XOR:          res = acc ^ opnd;
         ALU_OR:           res = acc | opnd;
         ALU_RLC:          res = {acc[6:0], acc[7]};
         ALU_RRC:          res = {acc[0], acc[7:1]};
         ALU_RAL:          res = {acc[6:0], flags.c};
         ALU_RAR:          res = {flags.c, acc[7:1]};
         ALU_CMA:          res = ~acc;
         ALU_STC, ALU_CMC: res = acc;
         ALU_LOAD:         res = opnd;
         default:          res = sum[7:0];
      endcase
   end

   always_comb
   begin
      case (exec.alu_op)
         ALU_AND, ALU_XOR, ALU_OR: c_nxt = 1'b0;
         ALU_RLC, ALU_RAL:         c_nxt = acc[7];
         ALU_RRC, ALU_RAR:         c_nxt = acc[0];
         ALU_STC:                  c_nxt = 1'b1;
         ALU_CMC:                  c_nxt = !flags.c;
         default:                  c_nxt = sub_op ? !sum[8] : sum[8];
      endcase
   end

   assign upd_szp = exec.alu_op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB,
                                        ALU_AND, ALU_XOR, ALU_OR, ALU_CMP};
   assign upd_c   = upd_szp
                    || exec.alu_op inside {ALU_RLC, ALU_RRC, ALU_RAL, ALU_RAR, ALU_STC, ALU_CMC};
   // compare sets the flags and keeps A
   assign acc_we  = (exec.alu_op != ALU_CMP);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         acc   <= '0;
         flags <= '0;
      end
      else if (exec.strobe)
      begin
         if (acc_we)
            acc <= res;
         if (upd_szp)
         begin
            flags.s <= res[7];
            flags.z <= (res == '0);
            flags.p <= ~^res;
         end
         if (upd_c)
            flags.c <= c_nxt;
      end
   end

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder
   import bus_pkg::*, isa_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  byte_t      din,
   input  logic       data_strobe,
   input  logic       cycle_end,
   input  psw_t       flags,
   output mcycle_t    cyc,
   output exec_ctrl_t exec,
   output addr_ctrl_t actl
);

   typedef enum logic [1:0] {
      M1,
      M2,
      M3
   } mstate_e;

   mstate_e   mstate;
   mstate_e   mstate_nxt;
   cyc_kind_e nxt_kind;
   byte_t     ir;
   cond_e     cond;
   logic      grp_acc;
   logic      grp_alui;
   logic      grp_jcc;
   logic      is_mvi;
   logic      is_jmp;
   logic      is_out;
   logic      is_jump;
   logic      cond_met;
   logic      exec_here;

   // opcode is taken straight from the pins in M1
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ir     <= OPC_NOP;
         mstate <= M1;
      end
      else
      begin
         if (data_strobe && mstate == M1)
            ir <= din;
         if (cycle_end)
            mstate <= mstate_nxt;
      end
   end

   assign grp_acc  = ir[GRP_HI:GRP_LO] == GRP_ACC && ir[LOW_HI:LOW_LO] == LOW_ACC
                     && ir[SEL_HI:SEL_LO] != SEL_DAA;
   assign grp_alui = ir[GRP_HI:GRP_LO] == GRP_IMM && ir[LOW_HI:LOW_LO] == LOW_ALUI;
   assign grp_jcc  = ir[GRP_HI:GRP_LO] == GRP_IMM && ir[LOW_HI:LOW_LO] == LOW_JCC;
   assign is_mvi   = (ir == OPC_MVI_A);
   assign is_jmp   = (ir == OPC_JMP);
   assign is_out   = (ir == OPC_OUT);
   assign is_jump  = is_jmp || grp_jcc;

   assign cond = cond_e'(ir[SEL_HI:SEL_LO]);

   always_comb
   begin
      case (cond)
         COND_NZ: cond_met = !flags.z;
         COND_Z:  cond_met = flags.z;
         COND_NC: cond_met = !flags.c;
         COND_C:  cond_met = flags.c;
         COND_PO: cond_met = !flags.p;
         COND_PE: cond_met = flags.p;
         COND_P:  cond_met = !flags.s;
         default: cond_met = flags.s;
      endcase
   end

   // next machine cycle, sampled by the bus controller at the end of T3
   always_comb
   begin
      mstate_nxt = M1;
      nxt_kind   = CYC_FETCH;
      case (mstate)
         M1:
            if (is_mvi || grp_alui || is_out || is_jump)
            begin
               mstate_nxt = M2;
               nxt_kind   = CYC_READ;
            end
         M2:
            if (is_out || is_jump)
            begin
               mstate_nxt = M3;
               nxt_kind   = is_out ? CYC_IO_WRITE : CYC_READ;
            end
         default:
            mstate_nxt = M1;
      endcase
   end

   assign cyc.kind = nxt_kind;
   assign cyc.m1   = (nxt_kind == CYC_FETCH);

   // accumulator group runs in M1, immediates once their operand is in
   always_comb
   begin
      case (mstate)
         M1:      exec_here = grp_acc;
         M2:      exec_here = is_mvi || grp_alui;
         default: exec_here = 1'b0;
      endcase
   end

   assign exec.alu_op = is_mvi ? ALU_LOAD : alu_op_e'({grp_acc, ir[SEL_HI:SEL_LO]});
   assign exec.strobe = cycle_end && exec_here;

   // only the io_write cycle of OUT leaves PC alone
   assign actl.pc_inc     = !(mstate == M3 && is_out);
   assign actl.wz_lo_load = (mstate == M2);
   assign actl.wz_hi_load = (mstate == M3) && is_jump;
   assign actl.pc_from_wz = cycle_end && mstate == M3 && (is_jmp || (grp_jcc && cond_met));
   assign actl.addr_load  = cycle_end;
   assign actl.port_sel   = (nxt_kind == CYC_IO_WRITE);

endmodule

/* hw/bus_cycle_ctrl.sv */
`timescale 1ns/10ps

module bus_cycle_ctrl
   import bus_pkg::*, isa_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      ready,
   input  mcycle_t   cyc,
   input  byte_t     acc,
   output tstate_e   tstate,
   output logic      data_strobe,
   output logic      cycle_end,
   output bus_ctrl_t bus,
   output byte_t     dout
);

   tstate_e tstate_nxt;
   mcycle_t cur;
   logic    xfer_nxt;
   logic    is_write;

   always_comb
   begin
      case (tstate)
         T1:      tstate_nxt = T2;
         T2, TW:  tstate_nxt = ready ? T3 : TW;
         default: tstate_nxt = T1;
      endcase
   end

   assign data_strobe = (tstate == T2 || tstate == TW) && ready;
   assign cycle_end   = (tstate == T3);
   assign is_write    = (cur.kind == CYC_IO_WRITE);
   assign xfer_nxt    = (tstate_nxt == T2 || tstate_nxt == TW);

   // reset parks the machine in T3, the first edge afterwards opens a T1
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         tstate <= T3;
         cur    <= '{kind: CYC_FETCH, m1: 1'b1};
         bus    <= '{sync: 1'b0, dbin: 1'b0, wr_n: 1'b1, waiting: 1'b0};
      end
      else
      begin
         tstate <= tstate_nxt;
         // the decoder's request becomes the running cycle
         if (cycle_end)
            cur <= cyc;
         bus.sync    <= (tstate_nxt == T1);
         bus.dbin    <= xfer_nxt && !is_write;
         bus.wr_n    <= !(xfer_nxt && is_write);
         bus.waiting <= (tstate_nxt == TW);
      end
   end

   // status byte in T1, accumulator while a write is on the bus
   always_comb
   begin
      dout = '0;
      if (tstate == T1)
      begin
         dout[STAT_MEMR] = (cur.kind == CYC_FETCH || cur.kind == CYC_READ);
         dout[STAT_M1]   = cur.m1;
         dout[STAT_OUT]  = is_write;
         dout[STAT_WO_N] = !is_write;
      end
      else if (is_write && (tstate == T2 || tstate == TW))
         dout = acc;
   end

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

   localparam logic [7:0] OPC_NOP   = 8'h00;
   localparam logic [7:0] OPC_MVI_A = 8'h3e;
   localparam logic [7:0] OPC_JMP   = 8'hc3;
   localparam logic [7:0] OPC_OUT   = 8'hd3;

   // group in bits 7:6 and the operation or condition in bits 5:3
   localparam int GRP_HI = 7;
   localparam int GRP_LO = 6;
   localparam int SEL_HI = 5;
   localparam int SEL_LO = 3;
   localparam int LOW_HI = 2;
   localparam int LOW_LO = 0;

   localparam logic [1:0] GRP_ACC  = 2'b00;
   localparam logic [1:0] GRP_IMM  = 2'b11;
   localparam logic [2:0] LOW_ACC  = 3'b111;
   localparam logic [2:0] LOW_ALUI = 3'b110;
   localparam logic [2:0] LOW_JCC  = 3'b010;
   // DAA slot of the accumulator group, runs as a no-op here
   localparam logic [2:0] SEL_DAA  = 3'b100;

   // immediates take {0, sel}, accumulator group takes {1, sel}
   typedef enum logic [3:0] {
      ALU_ADD  = 4'h0,
      ALU_ADC  = 4'h1,
      ALU_SUB  = 4'h2,
      ALU_SBB  = 4'h3,
      ALU_AND  = 4'h4,
      ALU_XOR  = 4'h5,
      ALU_OR   = 4'h6,
      ALU_CMP  = 4'h7,
      ALU_RLC  = 4'h8,
      ALU_RRC  = 4'h9,
      ALU_RAL  = 4'ha,
      ALU_RAR  = 4'hb,
      ALU_LOAD = 4'hc,
      ALU_CMA  = 4'hd,
      ALU_STC  = 4'he,
      ALU_CMC  = 4'hf
   } alu_op_e;

   typedef enum logic [2:0] {
      COND_NZ,
      COND_Z,
      COND_NC,
      COND_C,
      COND_PO,
      COND_PE,
      COND_P,
      COND_M
   } cond_e;

   typedef enum logic [1:0] {
      CYC_FETCH,
      CYC_READ,
      CYC_IO_WRITE
   } cyc_kind_e;

   typedef struct packed {
      logic s;
      logic z;
      logic p;
      logic c;
   } psw_t;

   typedef struct packed {
      cyc_kind_e kind;
      logic      m1;
   } mcycle_t;

   typedef struct packed {
      alu_op_e alu_op;
      logic    strobe;
   } exec_ctrl_t;

   // pc_inc and the wz loads are qualified by data_strobe in addr_regs
   typedef struct packed {
      logic pc_inc;
      logic wz_lo_load;
      logic wz_hi_load;
      logic pc_from_wz;
      logic addr_load;
      logic port_sel;
   } addr_ctrl_t;

endpackage

/* hw/bus_pkg.sv */
package bus_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // status byte bit positions on dout during T1, the other bits stay zero
   localparam int STAT_MEMR = 7;
   localparam int STAT_M1   = 5;
   localparam int STAT_OUT  = 4;
   localparam int STAT_WO_N = 1;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] byte_t;

   // a machine cycle runs T1, T2, any number of TW, then T3
   typedef enum logic [1:0] {
      T1,
      T2,
      TW,
      T3
   } tstate_e;

   // levels of the bus control pins
   typedef struct packed {
      logic sync;
      logic dbin;
      logic wr_n;
      // drives the wait pin, high in every TW
      logic waiting;
   } bus_ctrl_t;

endpackage
